/* vex_pkg.sv */
// --------------------
// Vector lane package
// Widths, RVV operation codes, reduction identities and stage structs
// --------------------
package vex_pkg;

    // --------------------
    // Widths and latency
    // --------------------
    localparam int XLEN     = 32;
    localparam int FUNCT6_W = 6;

    // Issue to writeback, three stage registers plus writeback register
    localparam int PIPE_DEPTH = 4;

    typedef logic [FUNCT6_W-1:0] funct6_t;

    // --------------------
    // Element operations
    // --------------------
    localparam funct6_t funct6_vadd  = 6'b000000;
    localparam funct6_t funct6_vsub  = 6'b000010;
    localparam funct6_t funct6_vminu = 6'b000100;
    localparam funct6_t funct6_vmin  = 6'b000101;
    localparam funct6_t funct6_vmaxu = 6'b000110;
    localparam funct6_t funct6_vmax  = 6'b000111;
    localparam funct6_t funct6_vand  = 6'b001001;
    localparam funct6_t funct6_vor   = 6'b001010;
    localparam funct6_t funct6_vxor  = 6'b001011;

    // --------------------
    // Reduction operations
    // --------------------
    localparam funct6_t funct6_vredsum  = 6'b000000;
    localparam funct6_t funct6_vredand  = 6'b000001;
    localparam funct6_t funct6_vredor   = 6'b000010;
    localparam funct6_t funct6_vredxor  = 6'b000011;
    localparam funct6_t funct6_vredminu = 6'b000100;
    localparam funct6_t funct6_vredmin  = 6'b000101;
    localparam funct6_t funct6_vredmaxu = 6'b000110;
    localparam funct6_t funct6_vredmax  = 6'b000111;

    // Start values when the head element is masked off
    localparam logic [XLEN-1:0] rdc_ident_zero = '0;
    localparam logic [XLEN-1:0] rdc_ident_ones = '1;
    localparam logic [XLEN-1:0] rdc_ident_smax = {1'b0, {(XLEN-1){1'b1}}};
    localparam logic [XLEN-1:0] rdc_ident_smin = {1'b1, {(XLEN-1){1'b0}}};

    // --------------------
    // Structs
    // --------------------
    typedef struct packed {
        logic            valid;
        logic            is_rdc;
        logic            head;
        logic            last;
        logic            mask;
        funct6_t         funct6;
        logic [XLEN-1:0] data_a;  // vs1, or reduction scalar
        logic [XLEN-1:0] data_b;  // vs2 element
    } vex_issue_t;

    typedef struct packed {
        logic            valid;
        logic            is_rdc;
        logic            head;
        logic            last;
        logic            mask;
        funct6_t         funct6;
        logic [XLEN-1:0] scalar;
        logic [XLEN-1:0] data;
    } vex_stage_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] data;
    } vex_rdc_res_t;

endpackage

/* vex_int_alu.sv */
// --------------------
// Integer element ALU
// Combinational element-wise result at the issue stage
// --------------------
`timescale 1ns/100ps

module vex_int_alu (
    input  vex_pkg::vex_issue_t        issue_i,
    output logic [vex_pkg::XLEN-1:0]   alu_data_o
);

    logic [vex_pkg::XLEN-1:0] vs1;
    logic [vex_pkg::XLEN-1:0] vs2;
    logic                     lt_u;
    logic                     lt_s;
    logic [vex_pkg::XLEN-1:0] elem_res;

    assign vs1 = issue_i.data_a;
    assign vs2 = issue_i.data_b;

    // Shared comparators for the min/max group
    assign lt_u = vs2 < vs1;
    assign lt_s = $signed(vs2) < $signed(vs1);

    // --------------------
    // Element decode
    // --------------------
    always_comb begin
        case (issue_i.funct6)
            vex_pkg::funct6_vadd: begin
                elem_res = vs2 + vs1;
            end
            vex_pkg::funct6_vsub: begin
                // vd = vs2 - vs1
                elem_res = vs2 - vs1;
            end
            vex_pkg::funct6_vminu: begin
                elem_res = lt_u ? vs2 : vs1;
            end
            vex_pkg::funct6_vmin: begin
                elem_res = lt_s ? vs2 : vs1;
            end
            vex_pkg::funct6_vmaxu: begin
                elem_res = lt_u ? vs1 : vs2;
            end
            vex_pkg::funct6_vmax: begin
                elem_res = lt_s ? vs1 : vs2;
            end
            vex_pkg::funct6_vand: begin
                elem_res = vs2 & vs1;
            end
            vex_pkg::funct6_vor: begin
                elem_res = vs2 | vs1;
            end
            vex_pkg::funct6_vxor: begin
                elem_res = vs2 ^ vs1;
            end
            default: begin
                elem_res = '0;
            end
        endcase
    end

    // Reduction elements carry vs2 raw into the accumulator
    assign alu_data_o = issue_i.is_rdc ? vs2 : elem_res;

endmodule

/* vex_pipe_regs.sv */
// --------------------
// Lane stage registers
// EX1 to EX3 shift and the masked writeback register
// --------------------
`timescale 1ns/100ps

module vex_pipe_regs (
    input  logic                      clk,
    input  logic                      rst_n,
    input  vex_pkg::vex_issue_t       issue_i,
    input  logic [vex_pkg::XLEN-1:0]  alu_data_i,
    input  vex_pkg::vex_rdc_res_t     rdc_res_i,
    output vex_pkg::vex_stage_t       stage_ex3_o,
    output logic                      wr_en_o,
    output logic [vex_pkg::XLEN-1:0]  wr_data_o,
    output logic                      rdc_done_o
);

    // EX1..EX3, the writeback register is the last pipe step
    logic [vex_pkg::PIPE_DEPTH-2:0] vld_q;
    vex_pkg::vex_stage_t            stage_q [vex_pkg::PIPE_DEPTH-1];
    vex_pkg::vex_stage_t            ex1_d;
    logic                           elem_wb;
    logic                           wr_en_q;
    logic                           rdc_done_q;
    logic [vex_pkg::XLEN-1:0]       wr_data_q;

    assign ex1_d.valid  = issue_i.valid;
    assign ex1_d.is_rdc = issue_i.is_rdc;
    assign ex1_d.head   = issue_i.head;
    assign ex1_d.last   = issue_i.last;
    assign ex1_d.mask   = issue_i.mask;
    assign ex1_d.funct6 = issue_i.funct6;
    assign ex1_d.scalar = issue_i.data_a;
    assign ex1_d.data   = alu_data_i;

    // --------------------
    // Stage shift
    // --------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[vex_pkg::PIPE_DEPTH-3:0], issue_i.valid};
        end
    end

    // Payload moves only behind a valid
    always_ff @(posedge clk) begin
        if (issue_i.valid) begin
            stage_q[0] <= ex1_d;
        end
        for (int i = 1; i < vex_pkg::PIPE_DEPTH - 1; i++) begin
            if (vld_q[i-1]) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    always_comb begin
        stage_ex3_o       = stage_q[vex_pkg::PIPE_DEPTH-2];
        stage_ex3_o.valid = vld_q[vex_pkg::PIPE_DEPTH-2];
    end

    // --------------------
    // Writeback
    // --------------------
    assign elem_wb = stage_ex3_o.valid & !stage_ex3_o.is_rdc;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_en_q    <= 1'b0;
            rdc_done_q <= 1'b0;
        end else begin
            wr_en_q    <= rdc_res_i.valid | elem_wb;
            rdc_done_q <= rdc_res_i.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (rdc_res_i.valid) begin
            wr_data_q <= rdc_res_i.data;
        end else if (elem_wb) begin
            // Inactive elements still write, as zero
            wr_data_q <= stage_ex3_o.mask ? stage_ex3_o.data : '0;
        end
    end

    assign wr_en_o    = wr_en_q;
    assign wr_data_o  = wr_data_q;
    assign rdc_done_o = rdc_done_q;

    a_wr_en_known: assert property (@(posedge clk) disable iff (!rst_n)
        !$isunknown(wr_en_o));

endmodule

/* vex_rdc_accum.sv */
// --------------------
// Lane-0 reduction accumulator
// Folds elements leaving EX3 and forms the final result with the scalar
// --------------------
`timescale 1ns/100ps

module vex_rdc_accum (
    input  logic                  clk,
    input  logic                  rst_n,
    input  vex_pkg::vex_stage_t   stage_i,
    output vex_pkg::vex_rdc_res_t rdc_res_o
);

    logic [vex_pkg::XLEN-1:0] acc_q;
    logic [vex_pkg::XLEN-1:0] acc_d;
    logic                     rdc_elem;
    logic                     seq_open_q;

    // --------------------
    // Reduction operators
    // --------------------
    function automatic logic [vex_pkg::XLEN-1:0] rdc_combine(
        input vex_pkg::funct6_t         op,
        input logic [vex_pkg::XLEN-1:0] a,
        input logic [vex_pkg::XLEN-1:0] b
    );
        logic [vex_pkg::XLEN-1:0] res;
        case (op)
            vex_pkg::funct6_vredsum:  res = a + b;
            vex_pkg::funct6_vredand:  res = a & b;
            vex_pkg::funct6_vredor:   res = a | b;
            vex_pkg::funct6_vredxor:  res = a ^ b;
            vex_pkg::funct6_vredminu: res = (a < b) ? a : b;
            vex_pkg::funct6_vredmin:  res = ($signed(a) < $signed(b)) ? a : b;
            vex_pkg::funct6_vredmaxu: res = (a > b) ? a : b;
            vex_pkg::funct6_vredmax:  res = ($signed(a) > $signed(b)) ? a : b;
            default:                  res = '0;
        endcase
        return res;
    endfunction

    // Neutral start value per operation
    function automatic logic [vex_pkg::XLEN-1:0] rdc_ident(input vex_pkg::funct6_t op);
        logic [vex_pkg::XLEN-1:0] res;
        case (op)
            vex_pkg::funct6_vredand,
            vex_pkg::funct6_vredminu: res = vex_pkg::rdc_ident_ones;
            vex_pkg::funct6_vredmin:  res = vex_pkg::rdc_ident_smax;
            vex_pkg::funct6_vredmax:  res = vex_pkg::rdc_ident_smin;
            default:                  res = vex_pkg::rdc_ident_zero;
        endcase
        return res;
    endfunction

    assign rdc_elem = stage_i.valid & stage_i.is_rdc;

    // --------------------
    // Accumulator update
    // --------------------
    always_comb begin
        if (stage_i.head) begin
            acc_d = stage_i.mask ? stage_i.data : rdc_ident(stage_i.funct6);
        end else if (stage_i.mask) begin
            acc_d = rdc_combine(stage_i.funct6, acc_q, stage_i.data);
        end else begin
            // Masked element leaves the fold untouched
            acc_d = acc_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rdc_elem) begin
            acc_q <= acc_d;
        end
    end

    // Final value goes straight to the writeback register
    assign rdc_res_o.valid = rdc_elem & stage_i.last;
    assign rdc_res_o.data  = rdc_combine(stage_i.funct6, acc_d, stage_i.scalar);

    // Open between a head and its end element
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            seq_open_q <= 1'b0;
        end else if (rdc_elem) begin
            seq_open_q <= !stage_i.last;
        end
    end

    // --------------------
    // Checks
    // --------------------
    a_last_is_rdc: assert property (@(posedge clk) disable iff (!rst_n)
        stage_i.valid && stage_i.last |-> stage_i.is_rdc);

    a_body_after_head: assert property (@(posedge clk) disable iff (!rst_n)
        rdc_elem && !stage_i.head |-> seq_open_q);

endmodule

/* vex_lane.sv */
// --------------------
// Vector execution lane
// Integer ALU, stage registers and reduction accumulator
// --------------------
`timescale 1ns/100ps

module vex_lane (
    input  logic                      clk,
    input  logic                      rst_n,
    input  vex_pkg::vex_issue_t       issue_i,
    output logic                      wr_en_o,
    output logic [vex_pkg::XLEN-1:0]  wr_data_o,
    output logic                      rdc_done_o
);

    logic [vex_pkg::XLEN-1:0] alu_data;
    vex_pkg::vex_stage_t      stage_ex3;
    vex_pkg::vex_rdc_res_t    rdc_res;

    // --------------------
    // Issue stage ALU
    // --------------------
    vex_int_alu vex_int_alu_inst (
        .issue_i    (issue_i ),
        .alu_data_o (alu_data)
    );

    // --------------------
    // EX1..EX3 and writeback
    // --------------------
    vex_pipe_regs vex_pipe_regs_inst (
        .clk         (clk       ),
        .rst_n       (rst_n     ),
        .issue_i     (issue_i   ),
        .alu_data_i  (alu_data  ),
        .rdc_res_i   (rdc_res   ),
        .stage_ex3_o (stage_ex3 ),
        .wr_en_o     (wr_en_o   ),
        .wr_data_o   (wr_data_o ),
        .rdc_done_o  (rdc_done_o)
    );

    // --------------------
    // Reduction fold
    // --------------------
    vex_rdc_accum vex_rdc_accum_inst (
        .clk       (clk      ),
        .rst_n     (rst_n    ),
        .stage_i   (stage_ex3),
        .rdc_res_o (rdc_res  )
    );

    // Fixed latency, no stalls anywhere in the lane
    a_elem_latency: assert property (@(posedge clk) disable iff (!rst_n)
        issue_i.valid && !issue_i.is_rdc
        |-> ##(vex_pkg::PIPE_DEPTH) (wr_en_o && !rdc_done_o));

    // End element yields the final reduction write
    a_rdc_latency: assert property (@(posedge clk) disable iff (!rst_n)
        issue_i.valid && issue_i.is_rdc && issue_i.last
        |-> ##(vex_pkg::PIPE_DEPTH) (wr_en_o && rdc_done_o));

endmodule

/* tb_vex_lane.sv */
// --------------------
// Vector lane testbench
// Table-driven stimulus, reference model and in-order write checks
// --------------------
`timescale 1ns/100ps

module tb_vex_lane;

    // One table row with stimulus and the write it should produce
    typedef struct packed {
        vex_pkg::vex_issue_t      issue;
        logic                     exp_wr;
        logic                     exp_done;
        logic [vex_pkg::XLEN-1:0] exp_data;
    } stim_row_t;

    typedef struct packed {
        int                       due;
        logic                     done;
        logic [vex_pkg::XLEN-1:0] data;
    } exp_write_t;

    logic                     clk;
    logic                     rst_n;
    vex_pkg::vex_issue_t      issue;
    logic                     wr_en;
    logic [vex_pkg::XLEN-1:0] wr_data;
    logic                     rdc_done;

    stim_row_t                rows[$];
    exp_write_t               exp_q[$];
    logic [vex_pkg::XLEN-1:0] model_acc;
    int                       seed;
    int                       cyc;
    int                       run_limit;
    int                       checks;
    int                       errors;

    vex_lane vex_lane_inst (
        .clk        (clk     ),
        .rst_n      (rst_n   ),
        .issue_i    (issue   ),
        .wr_en_o    (wr_en   ),
        .wr_data_o  (wr_data ),
        .rdc_done_o (rdc_done)
    );

    always #2 clk = ~clk;

    // --------------------
    // Reference model
    // --------------------
    function automatic logic [vex_pkg::XLEN-1:0] elem_ref(
        input vex_pkg::funct6_t         op,
        input logic [vex_pkg::XLEN-1:0] a,
        input logic [vex_pkg::XLEN-1:0] b
    );
        logic [vex_pkg::XLEN-1:0] r;
        case (op)
            vex_pkg::funct6_vadd:  r = b + a;
            vex_pkg::funct6_vsub:  r = b - a;
            vex_pkg::funct6_vminu: r = (a < b) ? a : b;
            vex_pkg::funct6_vmin:  r = ($signed(a) < $signed(b)) ? a : b;
            vex_pkg::funct6_vmaxu: r = (a < b) ? b : a;
            vex_pkg::funct6_vmax:  r = ($signed(a) < $signed(b)) ? b : a;
            vex_pkg::funct6_vand:  r = a & b;
            vex_pkg::funct6_vor:   r = a | b;
            vex_pkg::funct6_vxor:  r = a ^ b;
            default:               r = '0;
        endcase
        return r;
    endfunction

    function automatic logic [vex_pkg::XLEN-1:0] fold_ref(
        input vex_pkg::funct6_t         op,
        input logic [vex_pkg::XLEN-1:0] x,
        input logic [vex_pkg::XLEN-1:0] y
    );
        logic [vex_pkg::XLEN-1:0] r;
        case (op)
            vex_pkg::funct6_vredsum:  r = x + y;
            vex_pkg::funct6_vredand:  r = x & y;
            vex_pkg::funct6_vredor:   r = x | y;
            vex_pkg::funct6_vredxor:  r = x ^ y;
            vex_pkg::funct6_vredminu: r = (y < x) ? y : x;
            vex_pkg::funct6_vredmin:  r = ($signed(y) < $signed(x)) ? y : x;
            vex_pkg::funct6_vredmaxu: r = (y < x) ? x : y;
            vex_pkg::funct6_vredmax:  r = ($signed(y) < $signed(x)) ? x : y;
            default:                  r = '0;
        endcase
        return r;
    endfunction

    function automatic logic [vex_pkg::XLEN-1:0] fold_start(input vex_pkg::funct6_t op);
        logic [vex_pkg::XLEN-1:0] r;
        case (op)
            vex_pkg::funct6_vredand:  r = vex_pkg::rdc_ident_ones;
            vex_pkg::funct6_vredminu: r = vex_pkg::rdc_ident_ones;
            vex_pkg::funct6_vredmin:  r = vex_pkg::rdc_ident_smax;
            vex_pkg::funct6_vredmax:  r = vex_pkg::rdc_ident_smin;
            default:                  r = vex_pkg::rdc_ident_zero;
        endcase
        return r;
    endfunction

    function automatic logic [vex_pkg::XLEN-1:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [vex_pkg::XLEN-1:0] flag_word(input logic f);
        logic [vex_pkg::XLEN-1:0] w;
        w    = '0;
        w[0] = f;
        return w;
    endfunction

    // --------------------
    // Table building
    // --------------------
    task automatic add_row(
        input logic                     is_rdc,
        input logic                     head,
        input logic                     last,
        input logic                     mask,
        input vex_pkg::funct6_t         op,
        input logic [vex_pkg::XLEN-1:0] a,
        input logic [vex_pkg::XLEN-1:0] b
    );
        stim_row_t row;
        row              = '0;
        row.issue.valid  = 1'b1;
        row.issue.is_rdc = is_rdc;
        row.issue.head   = head;
        row.issue.last   = last;
        row.issue.mask   = mask;
        row.issue.funct6 = op;
        row.issue.data_a = a;
        row.issue.data_b = b;
        if (!is_rdc) begin
            row.exp_wr   = 1'b1;
            row.exp_data = mask ? elem_ref(op, a, b) : '0;
        end else begin
            if (head) begin
                model_acc = mask ? b : fold_start(op);
            end else if (mask) begin
                model_acc = fold_ref(op, model_acc, b);
            end
            // Only the end element writes the fold combined with the scalar
            if (last) begin
                row.exp_wr   = 1'b1;
                row.exp_done = 1'b1;
                row.exp_data = fold_ref(op, model_acc, a);
            end
        end
        rows.push_back(row);
    endtask

    task automatic elem_row(input vex_pkg::funct6_t op, input logic mask,
                            input logic [vex_pkg::XLEN-1:0] a,
                            input logic [vex_pkg::XLEN-1:0] b);
        add_row(1'b0, 1'b0, 1'b0, mask, op, a, b);
    endtask

    task automatic gap_row();
        stim_row_t row;
        row = '0;
        rows.push_back(row);
    endtask

    task automatic build_table();
        elem_row(vex_pkg::funct6_vadd, 1'b1, rand_word(), rand_word());
        elem_row(vex_pkg::funct6_vsub, 1'b1, rand_word(), rand_word());
        elem_row(vex_pkg::funct6_vand, 1'b1, rand_word(), rand_word());
        elem_row(vex_pkg::funct6_vor,  1'b1, rand_word(), rand_word());
        elem_row(vex_pkg::funct6_vxor, 1'b1, rand_word(), rand_word());
        // Top bit set so signed and unsigned order differ
        elem_row(vex_pkg::funct6_vminu, 1'b1, 32'h8000_0010, 32'h0000_0005);
        elem_row(vex_pkg::funct6_vmin,  1'b1, 32'h8000_0010, 32'h0000_0005);
        elem_row(vex_pkg::funct6_vmaxu, 1'b1, 32'h0000_0005, 32'h8000_0010);
        elem_row(vex_pkg::funct6_vmax,  1'b1, 32'h0000_0005, 32'h8000_0010);
        gap_row();
        elem_row(vex_pkg::funct6_vadd, 1'b0, rand_word(), rand_word());
        elem_row(6'b111111, 1'b1, rand_word(), rand_word());
        gap_row();
        // Reduction flags in the order is_rdc head last mask
        add_row(1'b1, 1'b1, 1'b0, 1'b1, vex_pkg::funct6_vredsum, rand_word(), rand_word());
        add_row(1'b1, 1'b0, 1'b0, 1'b1, vex_pkg::funct6_vredsum, rand_word(), rand_word());
        add_row(1'b1, 1'b0, 1'b0, 1'b0, vex_pkg::funct6_vredsum, rand_word(), rand_word());
        add_row(1'b1, 1'b0, 1'b1, 1'b1, vex_pkg::funct6_vredsum, rand_word(), rand_word());
        add_row(1'b1, 1'b1, 1'b0, 1'b1, vex_pkg::funct6_vredand, rand_word(), rand_word());
        add_row(1'b1, 1'b0, 1'b1, 1'b1, vex_pkg::funct6_vredand, rand_word(), rand_word());
        add_row(1'b1, 1'b1, 1'b0, 1'b0, vex_pkg::funct6_vredor,  rand_word(), rand_word());
        add_row(1'b1, 1'b0, 1'b1, 1'b1, vex_pkg::funct6_vredor,  rand_word(), rand_word());
        add_row(1'b1, 1'b1, 1'b1, 1'b1, vex_pkg::funct6_vredxor, rand_word(), rand_word());
        add_row(1'b1, 1'b1, 1'b0, 1'b1, vex_pkg::funct6_vredminu, rand_word(), 32'h9000_0000);
        add_row(1'b1, 1'b0, 1'b0, 1'b1, vex_pkg::funct6_vredminu, rand_word(), 32'h0000_0040);
        add_row(1'b1, 1'b0, 1'b1, 1'b1, vex_pkg::funct6_vredminu, 32'h0000_0100, 32'hFFFF_0000);
        add_row(1'b1, 1'b1, 1'b0, 1'b1, vex_pkg::funct6_vredmin,  rand_word(), 32'h0000_0040);
        add_row(1'b1, 1'b0, 1'b1, 1'b1, vex_pkg::funct6_vredmin,  32'h0000_0100, 32'h9000_0000);
        add_row(1'b1, 1'b1, 1'b0, 1'b1, vex_pkg::funct6_vredmaxu, rand_word(), 32'h0000_0040);
        add_row(1'b1, 1'b0, 1'b1, 1'b1, vex_pkg::funct6_vredmaxu, 32'h0000_0100, 32'h9000_0000);
        // Masked head starts from the identity
        add_row(1'b1, 1'b1, 1'b0, 1'b0, vex_pkg::funct6_vredmax, rand_word(), rand_word());
        add_row(1'b1, 1'b0, 1'b0, 1'b1, vex_pkg::funct6_vredmax, rand_word(), 32'h8000_0005);
        add_row(1'b1, 1'b0, 1'b1, 1'b0, vex_pkg::funct6_vredmax, 32'hFFFF_FFF0, rand_word());
        gap_row();
        elem_row(vex_pkg::funct6_vadd, 1'b1, rand_word(), rand_word());
    endtask

    // --------------------
    // Drive and check
    // --------------------
    task automatic drive_row(input stim_row_t row);
        exp_write_t ent;
        issue = row.issue;
        if (row.exp_wr) begin
            ent.due  = cyc + vex_pkg::PIPE_DEPTH;
            ent.done = row.exp_done;
            ent.data = row.exp_data;
            exp_q.push_back(ent);
        end
    endtask

    task automatic check_val(input string name, input logic [vex_pkg::XLEN-1:0] got,
                             input logic [vex_pkg::XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            $display("Fail at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // Each write pops the oldest expected entry
    always @(negedge clk) begin
        exp_write_t ent;
        logic       due_now;
        if (rst_n) begin
            due_now = (exp_q.size() > 0) && (exp_q[0].due == cyc);
            check_val("wr_en_o", flag_word(wr_en), flag_word(due_now));
            if ((wr_en === 1'b1) && (exp_q.size() > 0)) begin
                ent = exp_q.pop_front();
                check_val("wr_data_o", wr_data, ent.data);
                check_val("rdc_done_o", flag_word(rdc_done), flag_word(ent.done));
            end else begin
                check_val("rdc_done_o", flag_word(rdc_done), flag_word(1'b0));
            end
        end
    end

    // Cycle count and run limit
    always @(posedge clk) begin
        cyc <= cyc + 1;
        if (cyc >= run_limit) begin
            $display("Timeout after %0d cycles, the run did not complete", cyc);
            $display("Finished with errors");
            $finish;
        end
    end

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        issue     = '0;
        cyc       = 0;
        checks    = 0;
        errors    = 0;
        seed      = 21108;
        model_acc = '0;
        build_table();
        run_limit = rows.size() + vex_pkg::PIPE_DEPTH + 20;
        repeat (5) @(negedge clk);
        rst_n = 1'b1;
        // Idle lane with no writes expected
        repeat (4) @(negedge clk);
        foreach (rows[i]) begin
            @(negedge clk);
            drive_row(rows[i]);
        end
        @(negedge clk);
        issue = '0;
        // Drain until empty or the oldest write is overdue
        while (exp_q.size() > 0 && exp_q[0].due >= cyc) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
        if (exp_q.size() > 0) begin
            $display("Expected writes that never appeared: %0d", exp_q.size());
            errors += exp_q.size();
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

/* all.f */
vex_pkg.sv
vex_int_alu.sv
vex_pipe_regs.sv
vex_rdc_accum.sv
vex_lane.sv
tb_vex_lane.sv

/* run.sh */
#!/bin/sh
# Build and run the vector lane testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module tb_vex_lane \
    -f all.f \
    --Mdir obj_dir -o sim_vex_lane

./obj_dir/sim_vex_lane > sim.log 2>&1 || true
cat sim.log

if grep -q "Finished with errors" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation log is clean"
